//--- src/cache_geom_pkg.sv
`default_nettype none

// Geometry and backing memory constants for the instruction fetch subsystem.
// The top level takes these as the defaults of its own parameters.
package cache_geom_pkg;

  // Program counter width in bits.
  parameter int ADDR_WIDTH = 32;

  // Width of one instruction word.
  parameter int INST_WIDTH = 32;

  // Number of lines in the direct-mapped cache.
  parameter int NUM_LINES = 64;

  // Words per cache line. Must be a power of two.
  parameter int LINE_WORDS = 4;

  // Depth of the backing instruction memory in words.
  parameter int MEM_WORDS = 4096;

  // Cycles from a queue pop to read data on the response port.
  parameter int MEM_LATENCY = 3;

  // Depth of the memory request queue.
  // The refill engine starts with this many credits.
  parameter int MEM_QDEPTH = 2;

endpackage

`default_nettype wire

//--- src/fetch_types_pkg.sv
`default_nettype none

// State encodings shared by the fetch path controllers.
package fetch_types_pkg;

  // Cache controller states.
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    DELIVER,
    REFILL,
    UPDATE
  } cache_state_t;

  // Line refill engine states.
  typedef enum logic [1:0] {
    R_IDLE,
    R_ISSUE,
    R_WAIT
  } refill_state_t;

endpackage

`default_nettype wire

//--- src/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem #(
  parameter int INST_WIDTH  = cache_geom_pkg::INST_WIDTH,
  parameter int MEM_WORDS   = cache_geom_pkg::MEM_WORDS,
  parameter int MEM_LATENCY = cache_geom_pkg::MEM_LATENCY,
  parameter int MEM_QDEPTH  = cache_geom_pkg::MEM_QDEPTH
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         load_en,
  input  wire logic [$clog2(MEM_WORDS)-1:0] load_addr,
  input  wire logic [INST_WIDTH-1:0]        load_data,
  input  wire logic                         mem_req_valid,
  input  wire logic [$clog2(MEM_WORDS)-1:0] mem_req_addr,
  output logic                              mem_credit,
  output logic                              mem_rsp_valid,
  output logic [INST_WIDTH-1:0]             mem_rsp_data
);

  localparam int MEM_AW = $clog2(MEM_WORDS);
  localparam int PTR_W  = (MEM_QDEPTH > 1) ? $clog2(MEM_QDEPTH) : 1;
  localparam int CNT_W  = $clog2(MEM_QDEPTH + 1);

  logic [INST_WIDTH-1:0]  mem_array [MEM_WORDS];
  logic [MEM_AW-1:0]      queue [MEM_QDEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   pop;
  logic [MEM_LATENCY-1:0] pipe_valid;
  logic [INST_WIDTH-1:0]  pipe_data [MEM_LATENCY];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(MEM_QDEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // The queue drains one entry per cycle, and every pop frees a credit.
  assign pop           = (count != '0);
  assign mem_credit    = pop;
  assign mem_rsp_valid = pipe_valid[MEM_LATENCY-1];
  assign mem_rsp_data  = pipe_data[MEM_LATENCY-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      pipe_valid <= '0;
    end else begin
      if (mem_req_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count         <= count + CNT_W'(mem_req_valid) - CNT_W'(pop);
      pipe_valid[0] <= pop;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem_array[load_addr] <= load_data;
    end
    if (mem_req_valid) begin
      queue[wr_ptr] <= mem_req_addr;
    end
    // The array read is the first stage of the latency pipeline.
    if (pop) begin
      pipe_data[0] <= mem_array[queue[rd_ptr]];
    end
    for (int i = 1; i < MEM_LATENCY; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

endmodule

`default_nettype wire

//--- src/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill #(
  parameter int ADDR_WIDTH = cache_geom_pkg::ADDR_WIDTH,
  parameter int INST_WIDTH = cache_geom_pkg::INST_WIDTH,
  parameter int LINE_WORDS = cache_geom_pkg::LINE_WORDS,
  parameter int MEM_WORDS  = cache_geom_pkg::MEM_WORDS,
  parameter int MEM_QDEPTH = cache_geom_pkg::MEM_QDEPTH
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         miss_start,
  input  wire logic [ADDR_WIDTH-1:0]        miss_pc,
  output logic                              mem_req_valid,
  output logic [$clog2(MEM_WORDS)-1:0]      mem_req_addr,
  input  wire logic                         mem_credit,
  input  wire logic                         mem_rsp_valid,
  input  wire logic [INST_WIDTH-1:0]        mem_rsp_data,
  output logic                              fill_valid,
  output logic [$clog2(LINE_WORDS)-1:0]     fill_offset,
  output logic [INST_WIDTH-1:0]             fill_data,
  output logic                              fill_done
);

  localparam int OFF_W   = $clog2(LINE_WORDS);
  localparam int MEM_AW  = $clog2(MEM_WORDS);
  localparam int LINE_AW = MEM_AW - OFF_W;
  localparam int CRED_W  = $clog2(MEM_QDEPTH + 1);

  fetch_types_pkg::refill_state_t state;

  logic [LINE_AW-1:0] line_base;
  logic [OFF_W-1:0]   issue_cnt;
  logic [OFF_W-1:0]   rsp_cnt;
  logic [CRED_W-1:0]  credits;
  logic               issue;
  logic               last_issue;
  logic               last_rsp;
  logic               rsp_take;

  // One word request per cycle, only while a queue slot is known to be free.
  assign issue      = (state == fetch_types_pkg::R_ISSUE) && (credits != '0);
  assign last_issue = issue && (issue_cnt == OFF_W'(LINE_WORDS - 1));
  assign rsp_take   = mem_rsp_valid && (state != fetch_types_pkg::R_IDLE);
  assign last_rsp   = rsp_take && (rsp_cnt == OFF_W'(LINE_WORDS - 1));

  assign mem_req_valid = issue;
  assign mem_req_addr  = {line_base, issue_cnt};

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= fetch_types_pkg::R_IDLE;
      credits    <= CRED_W'(MEM_QDEPTH);
      issue_cnt  <= '0;
      rsp_cnt    <= '0;
      fill_valid <= 1'b0;
      fill_done  <= 1'b0;
    end else begin
      credits    <= credits + CRED_W'(mem_credit) - CRED_W'(issue);
      fill_valid <= rsp_take;
      fill_done  <= fill_valid && (fill_offset == OFF_W'(LINE_WORDS - 1));
      if (issue) begin
        issue_cnt <= issue_cnt + 1'b1;
      end
      // Responses come back in request order, so a counter labels them.
      if (rsp_take) begin
        rsp_cnt <= rsp_cnt + 1'b1;
      end
      case (state)
        fetch_types_pkg::R_IDLE: begin
          if (miss_start) begin
            state     <= fetch_types_pkg::R_ISSUE;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
          end
        end
        fetch_types_pkg::R_ISSUE: begin
          if (last_issue) begin
            state <= fetch_types_pkg::R_WAIT;
          end
        end
        fetch_types_pkg::R_WAIT: begin
          if (last_rsp) begin
            state <= fetch_types_pkg::R_IDLE;
          end
        end
        default: begin
          state <= fetch_types_pkg::R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetch_types_pkg::R_IDLE && miss_start) begin
      line_base <= miss_pc[MEM_AW+1:OFF_W+2];
    end
    fill_offset <= rsp_cnt;
    fill_data   <= mem_rsp_data;
  end

endmodule

`default_nettype wire

//--- src/i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module i_cache #(
  parameter int ADDR_WIDTH = cache_geom_pkg::ADDR_WIDTH,
  parameter int INST_WIDTH = cache_geom_pkg::INST_WIDTH,
  parameter int NUM_LINES  = cache_geom_pkg::NUM_LINES,
  parameter int LINE_WORDS = cache_geom_pkg::LINE_WORDS
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          req_valid,
  input  wire logic [ADDR_WIDTH-1:0]         req_pc,
  input  wire logic                          flush,
  output logic                               req_credit,
  output logic                               resp_valid,
  output logic [INST_WIDTH-1:0]              resp_inst,
  output logic                               resp_hit,
  output logic                               miss_start,
  output logic [ADDR_WIDTH-1:0]              miss_pc,
  input  wire logic                          fill_valid,
  input  wire logic [$clog2(LINE_WORDS)-1:0] fill_offset,
  input  wire logic [INST_WIDTH-1:0]         fill_data,
  input  wire logic                          fill_done
);

  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = ADDR_WIDTH - IDX_W - OFF_W - 2;

  fetch_types_pkg::cache_state_t state;
  fetch_types_pkg::cache_state_t next_state;

  logic [INST_WIDTH-1:0] data_mem [NUM_LINES*LINE_WORDS];
  logic [TAG_W-1:0]      tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0]  valid;

  // Word address of the request being served. Byte offset bits are dropped.
  logic [ADDR_WIDTH-3:0]  pc_word;
  logic [OFF_W-1:0]       word_off;
  logic [IDX_W-1:0]       line_idx;
  logic [TAG_W-1:0]       pc_tag;
  logic                   hit;
  logic                   accept;

  assign word_off = pc_word[OFF_W-1:0];
  assign line_idx = pc_word[IDX_W+OFF_W-1:OFF_W];
  assign pc_tag   = pc_word[ADDR_WIDTH-3:IDX_W+OFF_W];
  assign hit      = valid[line_idx] && (tag_mem[line_idx] == pc_tag);
  assign miss_pc  = {pc_word, 2'b00};

  // A new request may arrive while idle or in the cycle the credit comes back.
  assign accept = req_valid &&
                  ((state == fetch_types_pkg::IDLE) || (state == fetch_types_pkg::DELIVER));

  always_comb begin
    next_state = state;
    case (state)
      fetch_types_pkg::IDLE: begin
        if (req_valid) begin
          next_state = fetch_types_pkg::LOOKUP;
        end
      end
      fetch_types_pkg::LOOKUP: begin
        if (hit) begin
          next_state = fetch_types_pkg::DELIVER;
        end else begin
          next_state = fetch_types_pkg::REFILL;
        end
      end
      fetch_types_pkg::DELIVER: begin
        if (req_valid) begin
          next_state = fetch_types_pkg::LOOKUP;
        end else begin
          next_state = fetch_types_pkg::IDLE;
        end
      end
      fetch_types_pkg::REFILL: begin
        if (fill_done) begin
          next_state = fetch_types_pkg::UPDATE;
        end
      end
      fetch_types_pkg::UPDATE: begin
        next_state = fetch_types_pkg::DELIVER;
      end
      default: begin
        next_state = fetch_types_pkg::IDLE;
      end
    endcase
  end

  // Control state. Response strobes are single-cycle pulses.
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= fetch_types_pkg::IDLE;
      valid      <= '0;
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
      req_credit <= 1'b0;
      miss_start <= 1'b0;
    end else begin
      state      <= next_state;
      resp_valid <= 1'b0;
      req_credit <= 1'b0;
      miss_start <= 1'b0;
      case (state)
        fetch_types_pkg::IDLE, fetch_types_pkg::DELIVER: begin
          if (flush) begin
            valid <= '0;
          end
        end
        fetch_types_pkg::LOOKUP: begin
          if (hit) begin
            resp_valid <= 1'b1;
            req_credit <= 1'b1;
            resp_hit   <= 1'b1;
          end else begin
            miss_start <= 1'b1;
          end
        end
        fetch_types_pkg::UPDATE: begin
          valid[line_idx] <= 1'b1;
          resp_valid      <= 1'b1;
          req_credit      <= 1'b1;
          resp_hit        <= 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  // Arrays and the response word.
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_word <= req_pc[ADDR_WIDTH-1:2];
    end
    if ((state == fetch_types_pkg::REFILL) && fill_valid) begin
      data_mem[{line_idx, fill_offset}] <= fill_data;
    end
    if (state == fetch_types_pkg::UPDATE) begin
      tag_mem[line_idx] <= pc_tag;
    end
    // On a miss the last fill word landed two cycles before UPDATE.
    if ((state == fetch_types_pkg::LOOKUP) || (state == fetch_types_pkg::UPDATE)) begin
      resp_inst <= data_mem[{line_idx, word_off}];
    end
  end

endmodule

`default_nettype wire

//--- src/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
  parameter int ADDR_WIDTH  = cache_geom_pkg::ADDR_WIDTH,
  parameter int INST_WIDTH  = cache_geom_pkg::INST_WIDTH,
  parameter int NUM_LINES   = cache_geom_pkg::NUM_LINES,
  parameter int LINE_WORDS  = cache_geom_pkg::LINE_WORDS,
  parameter int MEM_WORDS   = cache_geom_pkg::MEM_WORDS,
  parameter int MEM_LATENCY = cache_geom_pkg::MEM_LATENCY,
  parameter int MEM_QDEPTH  = cache_geom_pkg::MEM_QDEPTH
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         req_valid,
  input  wire logic [ADDR_WIDTH-1:0]        req_pc,
  input  wire logic                         flush,
  input  wire logic                         load_en,
  input  wire logic [$clog2(MEM_WORDS)-1:0] load_addr,
  input  wire logic [INST_WIDTH-1:0]        load_data,
  output logic                              req_credit,
  output logic                              resp_valid,
  output logic [INST_WIDTH-1:0]             resp_inst,
  output logic                              resp_hit
);

  localparam int OFF_W  = $clog2(LINE_WORDS);
  localparam int MEM_AW = $clog2(MEM_WORDS);

  logic                  miss_start;
  logic [ADDR_WIDTH-1:0] miss_pc;
  logic                  fill_valid;
  logic [OFF_W-1:0]      fill_offset;
  logic [INST_WIDTH-1:0] fill_data;
  logic                  fill_done;
  logic                  mem_req_valid;
  logic [MEM_AW-1:0]     mem_req_addr;
  logic                  mem_credit;
  logic                  mem_rsp_valid;
  logic [INST_WIDTH-1:0] mem_rsp_data;

  i_cache #(
    .ADDR_WIDTH(ADDR_WIDTH), .INST_WIDTH(INST_WIDTH),
    .NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)
  ) cache0 (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_pc(req_pc), .flush(flush),
    .req_credit(req_credit), .resp_valid(resp_valid), .resp_inst(resp_inst),
    .resp_hit(resp_hit), .miss_start(miss_start), .miss_pc(miss_pc),
    .fill_valid(fill_valid), .fill_offset(fill_offset), .fill_data(fill_data),
    .fill_done(fill_done)
  );

  line_refill #(
    .ADDR_WIDTH(ADDR_WIDTH), .INST_WIDTH(INST_WIDTH), .LINE_WORDS(LINE_WORDS),
    .MEM_WORDS(MEM_WORDS), .MEM_QDEPTH(MEM_QDEPTH)
  ) refill0 (
    .clk(clk), .reset(reset), .miss_start(miss_start), .miss_pc(miss_pc),
    .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr), .mem_credit(mem_credit),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
    .fill_valid(fill_valid), .fill_offset(fill_offset), .fill_data(fill_data),
    .fill_done(fill_done)
  );

  inst_mem #(
    .INST_WIDTH(INST_WIDTH), .MEM_WORDS(MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY), .MEM_QDEPTH(MEM_QDEPTH)
  ) mem0 (
    .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
    .mem_credit(mem_credit), .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data)
  );

endmodule

`default_nettype wire

//--- verification/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

  localparam int ADDR_WIDTH = cache_geom_pkg::ADDR_WIDTH;
  localparam int INST_WIDTH = cache_geom_pkg::INST_WIDTH;
  localparam int NUM_LINES  = cache_geom_pkg::NUM_LINES;
  localparam int LINE_WORDS = cache_geom_pkg::LINE_WORDS;
  localparam int MEM_WORDS  = cache_geom_pkg::MEM_WORDS;
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  localparam int OFF_W      = $clog2(LINE_WORDS);
  localparam int IDX_W      = $clog2(NUM_LINES);
  localparam int MAX_TESTS  = 64;
  localparam int TIMEOUT    = 200;
  localparam int OP_FETCH   = 0;
  localparam int OP_FLUSH   = 1;
  localparam int OP_LOAD    = 2;

  logic                  clk;
  logic                  reset;
  logic                  req_valid;
  logic [ADDR_WIDTH-1:0] req_pc;
  logic                  flush;
  logic                  load_en;
  logic [MEM_AW-1:0]     load_addr;
  logic [INST_WIDTH-1:0] load_data;
  logic                  req_credit;
  logic                  resp_valid;
  logic [INST_WIDTH-1:0] resp_inst;
  logic                  resp_hit;

  // Stimulus table. The expected columns are filled from the model before the run.
  string                 t_name [MAX_TESTS];
  int                    t_op [MAX_TESTS];
  logic [ADDR_WIDTH-1:0] t_pc [MAX_TESTS];
  logic [INST_WIDTH-1:0] t_data [MAX_TESTS];
  logic [INST_WIDTH-1:0] t_exp_inst [MAX_TESTS];
  logic                  t_exp_hit [MAX_TESTS];
  int                    n_tests;

  // Reference model of the memory image and of each cache line.
  logic [INST_WIDTH-1:0] image [MEM_WORDS];
  logic [INST_WIDTH-1:0] m_data [NUM_LINES*LINE_WORDS];
  logic [ADDR_WIDTH-1:0] m_tag [NUM_LINES];
  logic                  m_valid [NUM_LINES];

  int pass_count;
  int fail_count;

  ifetch_top dut0 (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_pc(req_pc), .flush(flush),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .req_credit(req_credit), .resp_valid(resp_valid), .resp_inst(resp_inst),
    .resp_hit(resp_hit)
  );

  always #20 clk = ~clk;

  function automatic int unsigned word_of(input logic [ADDR_WIDTH-1:0] pc);
    return (pc >> 2) % MEM_WORDS;
  endfunction

  function automatic int unsigned index_of(input logic [ADDR_WIDTH-1:0] pc);
    return (pc >> (2 + OFF_W)) % NUM_LINES;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] tag_of(input logic [ADDR_WIDTH-1:0] pc);
    return pc >> (2 + OFF_W + IDX_W);
  endfunction

  task automatic add_test(input string name, input int op, input logic [ADDR_WIDTH-1:0] pc,
                          input logic [INST_WIDTH-1:0] data);
    t_name[n_tests] = name;
    t_op[n_tests]   = op;
    t_pc[n_tests]   = pc;
    t_data[n_tests] = data;
    n_tests++;
  endtask

  task automatic build_table();
    logic [ADDR_WIDTH-1:0] pc;
    add_test("cold_miss", OP_FETCH, 32'h100, '0);
    add_test("hit_same_line", OP_FETCH, 32'h108, '0);
    add_test("hit_low_bits_ignored", OP_FETCH, 32'h103, '0);
    // 0x500 shares the index of 0x100 with another tag.
    add_test("conflict_evict", OP_FETCH, 32'h500, '0);
    add_test("conflict_return", OP_FETCH, 32'h100, '0);
    add_test("flush_lines", OP_FLUSH, '0, '0);
    add_test("reload_word", OP_LOAD, 32'h104, ~image[word_of(32'h104)]);
    add_test("fetch_after_reload", OP_FETCH, 32'h104, '0);
    add_test("hit_after_reload", OP_FETCH, 32'h10c, '0);
    add_test("flush_before_sweep", OP_FLUSH, '0, '0);
    // Two tags over four lines, so the sweep mixes hits, misses and evictions.
    for (int i = 0; i < 40; i++) begin
      pc = {21'd0, 1'($urandom()), 4'd0, 2'($urandom()), 4'($urandom())};
      add_test($sformatf("sweep_%0d", i), OP_FETCH, pc, '0);
    end
  endtask

  task automatic predict_table();
    int unsigned idx;
    int unsigned base;
    for (int i = 0; i < NUM_LINES; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int n = 0; n < n_tests; n++) begin
      idx           = index_of(t_pc[n]);
      t_exp_inst[n] = '0;
      t_exp_hit[n]  = 1'b0;
      if (t_op[n] == OP_FLUSH) begin
        for (int i = 0; i < NUM_LINES; i++) begin
          m_valid[i] = 1'b0;
        end
      end else if (t_op[n] == OP_LOAD) begin
        image[word_of(t_pc[n])] = t_data[n];
      end else begin
        if (m_valid[idx] && (m_tag[idx] == tag_of(t_pc[n]))) begin
          t_exp_hit[n] = 1'b1;
        end else begin
          base = word_of(t_pc[n]) - (word_of(t_pc[n]) % LINE_WORDS);
          for (int w = 0; w < LINE_WORDS; w++) begin
            m_data[idx*LINE_WORDS + w] = image[base + w];
          end
          m_tag[idx]   = tag_of(t_pc[n]);
          m_valid[idx] = 1'b1;
        end
        t_exp_inst[n] = m_data[idx*LINE_WORDS + (word_of(t_pc[n]) % LINE_WORDS)];
      end
    end
  endtask

  // Returns 1 when the response never came, so the run stops.
  task automatic run_fetch(input int n, output bit stuck);
    int                    cycles;
    logic                  got;
    logic                  credit_ok;
    logic [INST_WIDTH-1:0] inst;
    logic                  hit;
    cycles    = 0;
    got       = 1'b0;
    credit_ok = 1'b1;
    inst      = '0;
    hit       = 1'b0;
    stuck     = 1'b0;
    req_valid = 1'b1;
    req_pc    = t_pc[n];
    while (!got && cycles < TIMEOUT) begin
      @(negedge clk);
      req_valid = 1'b0;
      cycles++;
      if (req_credit !== resp_valid) begin
        credit_ok = 1'b0;
      end
      if (resp_valid === 1'b1) begin
        got  = 1'b1;
        inst = resp_inst;
        hit  = resp_hit;
      end
    end
    if (!got) begin
      $display("%s: the response never arrived within %0d cycles", t_name[n], TIMEOUT);
      fail_count++;
      stuck = 1'b1;
    end else if (!credit_ok) begin
      $display("%s: req_credit did not pulse together with the response", t_name[n]);
      fail_count++;
    end else if (inst !== t_exp_inst[n]) begin
      $display("FAILED %s: inst expected %h actual %h", t_name[n], t_exp_inst[n], inst);
      fail_count++;
    end else if (hit !== t_exp_hit[n]) begin
      $display("FAILED %s: hit expected %0d actual %0d", t_name[n], t_exp_hit[n], hit);
      fail_count++;
    end else if (t_exp_hit[n] && cycles != 2) begin
      $display("FAILED %s: hit latency expected 2 actual %0d", t_name[n], cycles);
      fail_count++;
    end else begin
      $display("PASS %s (inst %h hit %0d)", t_name[n], inst, hit);
      pass_count++;
    end
  endtask

  task automatic run_control(input int n);
    if (t_op[n] == OP_FLUSH) begin
      flush = 1'b1;
    end else begin
      load_en   = 1'b1;
      load_addr = MEM_AW'(word_of(t_pc[n]));
      load_data = t_data[n];
    end
    @(negedge clk);
    flush   = 1'b0;
    load_en = 1'b0;
    if (resp_valid !== 1'b0 || req_credit !== 1'b0) begin
      $display("%s: a response appeared with no request outstanding", t_name[n]);
      fail_count++;
    end else begin
      $display("PASS %s", t_name[n]);
      pass_count++;
    end
  endtask

  initial begin
    logic        reset_ok;
    bit          stuck;
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_pc    = '0;
    flush     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    pass_count = 0;
    fail_count = 0;
    n_tests    = 0;
    stuck      = 1'b0;
    reset_ok   = 1'b1;
    // The first draw also seeds the generator for the whole run.
    image[0] = $urandom(32'h5315ac62);
    for (int a = 1; a < MEM_WORDS; a++) begin
      image[a] = $urandom();
    end
    repeat (16) begin
      @(negedge clk);
      if (resp_valid !== 1'b0 || req_credit !== 1'b0) begin
        reset_ok = 1'b0;
      end
    end
    reset = 1'b0;
    // Boot load of the whole image, one word per cycle.
    for (int a = 0; a < MEM_WORDS; a++) begin
      load_en   = 1'b1;
      load_addr = MEM_AW'(a);
      load_data = image[a];
      @(negedge clk);
      if (resp_valid !== 1'b0 || req_credit !== 1'b0) begin
        reset_ok = 1'b0;
      end
    end
    load_en = 1'b0;
    if (!reset_ok) begin
      $display("reset_state: resp_valid or req_credit was not low during or after reset");
      fail_count++;
    end else begin
      $display("PASS reset_state");
      pass_count++;
    end
    build_table();
    predict_table();
    for (int n = 0; n < n_tests && !stuck; n++) begin
      if (t_op[n] == OP_FETCH) begin
        run_fetch(n, stuck);
      end else begin
        run_control(n);
      end
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ifetch.f
src/cache_geom_pkg.sv
src/fetch_types_pkg.sv
src/inst_mem.sv
src/line_refill.sv
src/i_cache.sv
src/ifetch_top.sv
verification/ifetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the instruction fetch testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module ifetch_tb -f ifetch.f

out=$(./obj_dir/Vifetch_tb)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
